/* filelist.f */
common/arith_pkg.sv
mult/mult_pipe.sv
div/div_iter.sv
div/signed_div.sv
verilog/arith_unit.sv
bench/arith_unit_asserts.sv
bench/arith_unit_tb.sv

/* Makefile */
# Verilator build and run for the multiply/divide unit

VERILATOR ?= verilator
TOP       ?= arith_unit_tb
FILELIST  ?= filelist.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert
LINTFLAGS ?= --lint-only -Wall --timing
PASS_MSG  ?= No errors

SIM_BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all build run lint clean

all: run

build: $(SIM_BIN)

$(SIM_BIN): $(FILELIST) $(shell cat $(FILELIST))
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) \
		--Mdir $(BUILD_DIR) -o V$(TOP)

# Pass only when the pass message shows up on a line of its own
run: build
	@out="$$($(SIM_BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

lint:
	$(VERILATOR) $(LINTFLAGS) -f $(FILELIST) --top-module $(TOP)

clean:
	rm -rf $(BUILD_DIR)

/* bench/arith_unit_tb.sv */
/*
  Testbench for the multiply/divide unit, random and directed requests
  checked against a reference model
*/
`timescale 1ns/1ps
`default_nettype none

module arith_unit_tb import arith_pkg::*;;

  localparam int num_ops = 600;

  // Q16.16 values 1.0, 0.5, -1.0, -0.5, 2.5 and -3.25
  localparam word_t fx_vals [6] = '{
    32'h0001_0000, 32'h0000_8000, 32'hffff_0000,
    32'hffff_8000, 32'h0002_8000, 32'hfffc_c000
  };

  logic       clk;
  logic       reset;
  logic       go;
  arith_req_t req;
  logic       done;
  arith_rsp_t rsp;

  arith_rsp_t exp_rsp;
  int         exp_lat;
  logic       checked;
  int         go_edges;
  int         errors;
  int         checks;
  int         ops;
  int         test_errors;
  int         test_ops;

  arith_unit arith_unit_inst (
    .clk   (clk),
    .reset (reset),
    .go    (go),
    .req   (req),
    .done  (done),
    .rsp   (rsp)
  );

  always #4 clk = ~clk;

  function automatic arith_rsp_t expected_rsp(input arith_req_t r);
    logic signed [2*word_w-1:0] sa;
    logic signed [2*word_w-1:0] sb;
    logic [2*word_w-1:0]        ua;
    logic [2*word_w-1:0]        ub;
    logic [2*word_w-1:0]        prod;
    arith_rsp_t                 e;
    sa = {{word_w{r.a[word_w-1]}}, r.a};
    sb = {{word_w{r.b[word_w-1]}}, r.b};
    ua = {{word_w{1'b0}}, r.a};
    ub = {{word_w{1'b0}}, r.b};
    e.hi = '0;
    if (r.is_signed)
      prod = sa * sb;
    else
      prod = ua * ub;
    if (r.op == op_mul) begin
      e.lo = prod[word_w-1:0];
    end else if (r.op == op_fxmul) begin
      e.lo = prod[frac_w +: word_w];
    end else if (r.b == '0) begin
      e.lo = '1;
      e.hi = r.a;
    end else if (r.is_signed) begin
      // Truncating division, remainder with the dividend's sign
      e.lo = word_t'(sa / sb);
      e.hi = word_t'(sa % sb);
    end else begin
      e.lo = r.a / r.b;
      e.hi = r.a % r.b;
    end
    return e;
  endfunction

  task automatic check_fields(input logic first);
    checks++;
    if (rsp.lo !== exp_rsp.lo) begin
      errors++;
      $display("Mismatch at %0t: rsp.lo got %h expected %h", $time, rsp.lo, exp_rsp.lo);
    end
    if (rsp.hi !== exp_rsp.hi) begin
      errors++;
      $display("Mismatch at %0t: rsp.hi got %h expected %h", $time, rsp.hi, exp_rsp.hi);
    end
    if (first && exp_lat != 0 && go_edges != exp_lat) begin
      errors++;
      $display("Mismatch at %0t: done latency got %0d expected %0d", $time, go_edges, exp_lat);
    end
  endtask

  // Compare on the falling edge, where DUT outputs are settled
  always @(negedge clk) begin
    if (reset || !go) begin
      go_edges = 0;
    end else begin
      if (done && !checked) begin
        check_fields(1'b1);
        checked = 1'b1;
      end else if (checked && !done) begin
        errors++;
        $display("done fell at %0t while go was still high", $time);
      end else if (checked) begin
        check_fields(1'b0);
      end
      go_edges++;
    end
  end

  task automatic run_op(input op_t op, input logic sgn, input word_t a, input word_t b,
                        input int hold);
    arith_req_t r;
    int         waited;
    r.op        = op;
    r.is_signed = sgn;
    r.a         = a;
    r.b         = b;
    @(posedge clk);
    req <= r;
    go  <= 1'b1;
    exp_rsp = expected_rsp(r);
    if (op != op_div)
      exp_lat = 3;
    else if (a == '0)
      exp_lat = 1;
    else
      exp_lat = 0;
    checked = 1'b0;
    ops++;
    test_ops++;
    waited = 0;
    while (!checked && waited < word_w + 10) begin
      @(posedge clk);
      waited++;
    end
    if (!checked) begin
      errors++;
      $display("No done at %0t for op %0d with a %h and b %h", $time, op, a, b);
    end
    repeat (hold) @(posedge clk);
    go <= 1'b0;
  endtask

  task automatic end_test(input string name);
    $display("%s: %0d ops, %0d errors", name, test_ops, errors - test_errors);
    test_ops    = 0;
    test_errors = errors;
  endtask

  initial begin
    word_t a;
    word_t b;
    word_t r;
    clk         = 1'b0;
    reset       = 1'b1;
    go          = 1'b0;
    req         = '0;
    checked     = 1'b0;
    exp_lat     = 0;
    errors      = 0;
    checks      = 0;
    ops         = 0;
    test_ops    = 0;
    test_errors = 0;
    void'($urandom(32'hdedf));
    repeat (2) @(posedge clk);
    reset <= 1'b0;
    @(negedge clk);
    if (done !== 1'b0) begin
      errors++;
      $display("done is not low after reset at %0t", $time);
    end

    for (int i = 0; i < 200; i++)
      run_op(op_mul, i[0], $urandom, $urandom, 0);
    end_test("integer multiply");

    for (int i = 0; i < 6; i++) begin
      for (int j = 0; j < 6; j++) begin
        run_op(op_fxmul, 1'b1, fx_vals[i], fx_vals[j], 0);
        run_op(op_fxmul, 1'b0, fx_vals[i], fx_vals[j], 0);
      end
    end
    for (int i = 0; i < 100; i++) begin
      // Mix of full-range and small values
      r = $urandom;
      a = i[1] ? {{8{r[23]}}, r[23:0]} : $urandom;
      b = $urandom;
      run_op(op_fxmul, i[0], a, b, 0);
    end
    end_test("fixed-point multiply");

    for (int i = 0; i < 100; i++) begin
      a = $urandom;
      b = $urandom >> ($urandom % 32);
      run_op(op_div, 1'b0, a, b, 0);
    end
    end_test("unsigned divide");

    for (int i = 0; i < 100; i++) begin
      a = ($urandom >> 1) >> ($urandom % 16);
      b = ($urandom >> 1) >> ($urandom % 31);
      if (b == '0)
        b = 3;
      run_op(op_div, 1'b1, i[0] ? -a : a, i[1] ? -b : b, 0);
    end
    run_op(op_div, 1'b1, -32'sd7, 32'sd2, 0);
    run_op(op_div, 1'b1, 32'sd7, -32'sd2, 0);
    run_op(op_div, 1'b1, -32'sd7, -32'sd2, 0);
    run_op(op_div, 1'b1, 32'h8000_0000, 32'hffff_ffff, 0);
    run_op(op_div, 1'b1, 32'h8000_0000, 32'h0000_0001, 0);
    end_test("signed divide");

    for (int s = 0; s < 2; s++) begin
      run_op(op_div, s[0], 32'd123, 32'd0, 0);
      run_op(op_div, s[0], -32'sd5, 32'd0, 0);
      run_op(op_div, s[0], 32'd0, 32'd7, 0);
      run_op(op_div, s[0], 32'd0, -32'sd7, 0);
      run_op(op_div, s[0], 32'd0, 32'd0, 0);
    end
    end_test("divide edge cases");

    // Abort a division halfway, then check the next one
    @(posedge clk);
    req <= '{op: op_div, is_signed: 1'b0, a: 32'hdead_beef, b: 32'd13};
    go  <= 1'b1;
    checked = 1'b0;
    exp_lat = 0;
    repeat (word_w / 2) @(posedge clk);
    go <= 1'b0;
    run_op(op_div, 1'b1, -32'sd1000, 32'sd7, 0);
    run_op(op_div, 1'b0, 32'hffff_fff0, 32'd9, 6);
    // done clears one cycle after go drops
    @(posedge clk);
    @(negedge clk);
    if (done !== 1'b0) begin
      errors++;
      $display("done is high at %0t after go was dropped", $time);
    end
    run_op(op_mul, 1'b1, -32'sd12345, 32'sd678, 6);
    end_test("handshake");

    $display("Summary: %0d ops, %0d checks, %0d errors", ops, checks, errors);
    if (errors == 0)
      $display("No errors");
    else
      $display("Errors found");
    $finish;
  end

  initial begin
    #((num_ops * (word_w + 10) + 200) * 8);
    $display("Timeout: run did not finish within the expected number of cycles");
    $display("Errors found");
    $finish;
  end

endmodule

`default_nettype wire

/* bench/arith_unit_asserts.sv */
/*
  Handshake assertions for the multiply/divide unit top level
*/
`timescale 1ns/1ps
`default_nettype none

module arith_unit_asserts import arith_pkg::*; (
  input logic       clk,
  input logic       reset,
  input logic       go,
  input logic       done,
  input arith_req_t req
);

  logic is_mul;

  assign is_mul = (req.op == op_mul) || (req.op == op_fxmul);

  done_after_reset: assert property (@(posedge clk) reset |=> !done)
    else $error("done high in the cycle after reset");

  // done needs go on the previous edge
  done_needs_go: assert property (@(posedge clk) disable iff (reset) done |-> $past(go))
    else $error("done high without go in the previous cycle");

  mul_latency: assert property (@(posedge clk) disable iff (reset)
    $rose(go) && is_mul |-> !done ##1 !done ##1 !done ##1 done)
    else $error("multiply done not exactly 3 cycles after go");

endmodule

bind arith_unit arith_unit_asserts arith_unit_asserts_inst (
  .clk   (clk),
  .reset (reset),
  .go    (go),
  .done  (done),
  .req   (req)
);

`default_nettype wire

/* verilog/arith_unit.sv */
/*
  Multiply/divide unit top level, routes a request to the
  multiplier or the divider and returns the selected result
*/
`timescale 1ns/1ps
`default_nettype none

module arith_unit import arith_pkg::*; (
  input  logic       clk,
  input  logic       reset,
  input  logic       go,
  input  arith_req_t req,
  output logic       done,
  output arith_rsp_t rsp
);

  logic  is_mul;
  logic  is_fixed;
  logic  is_div;
  logic  mult_go;
  logic  div_go;
  logic  mult_done;
  logic  div_done;
  word_t product;
  word_t quotient;
  word_t remainder;

  assign is_fixed = (req.op == op_fxmul);
  assign is_mul   = (req.op == op_mul) || is_fixed;
  assign is_div   = (req.op == op_div);
  assign mult_go  = go & is_mul;
  assign div_go   = go & is_div;

  mult_pipe mult_pipe_inst (
    .clk       (clk),
    .reset     (reset),
    .go        (mult_go),
    .is_signed (req.is_signed),
    .fixed     (is_fixed),
    .a         (req.a),
    .b         (req.b),
    .product   (product),
    .done      (mult_done)
  );

  signed_div signed_div_inst (
    .clk       (clk),
    .reset     (reset),
    .go        (div_go),
    .is_signed (req.is_signed),
    .a         (req.a),
    .b         (req.b),
    .quotient  (quotient),
    .remainder (remainder),
    .done      (div_done)
  );

  // Unused op code never completes
  always_comb begin
    done   = is_div ? div_done : (is_mul & mult_done);
    rsp.lo = is_div ? quotient : product;
    rsp.hi = is_div ? remainder : '0;
  end

endmodule

`default_nettype wire

/* div/signed_div.sv */
/*
  Signed/unsigned divider around the unsigned core, C-style results
  and a fixed answer for division by zero
*/
`timescale 1ns/1ps
`default_nettype none

module signed_div import arith_pkg::*; (
  input  logic  clk,
  input  logic  reset,
  input  logic  go,
  input  logic  is_signed,
  input  word_t a,
  input  word_t b,
  output word_t quotient,
  output word_t remainder,
  output logic  done
);

  logic  neg_a;
  logic  neg_b;
  logic  div_zero;
  word_t abs_a;
  word_t abs_b;
  word_t quo_raw;
  word_t rem_raw;

  assign neg_a    = is_signed & a[word_w-1];
  assign neg_b    = is_signed & b[word_w-1];
  assign div_zero = (b == '0);
  assign abs_a    = neg_a ? -a : a;
  assign abs_b    = neg_b ? -b : b;

  div_iter div_iter_inst (
    .clk       (clk),
    .reset     (reset),
    .go        (go),
    .dividend  (abs_a),
    .divisor   (abs_b),
    .quotient  (quo_raw),
    .remainder (rem_raw),
    .done      (done)
  );

  // Truncation toward zero, remainder follows the dividend's sign
  always_comb begin
    if (div_zero) begin
      quotient  = '1;
      remainder = a;
    end else begin
      quotient  = (neg_a ^ neg_b) ? -quo_raw : quo_raw;
      remainder = neg_a ? -rem_raw : rem_raw;
    end
  end

endmodule

`default_nettype wire

/* div/div_iter.sv */
/*
  Unsigned restoring divider, one quotient bit per cycle,
  driven by a go/done handshake
*/
`timescale 1ns/1ps
`default_nettype none

module div_iter import arith_pkg::*; (
  input  logic  clk,
  input  logic  reset,
  input  logic  go,
  input  word_t dividend,
  input  word_t divisor,
  output word_t quotient,
  output word_t remainder,
  output logic  done
);

  typedef logic [2*word_w-2:0] shift_t;

  div_state_e state;
  div_count_t count;
  word_t      rem;
  word_t      quo;
  word_t      mask;
  shift_t     div_sh;
  logic       fits;

  assign fits = div_sh <= shift_t'(rem);

  always_ff @(posedge clk) begin
    if (reset || !go) begin
      state <= idle;
      done  <= 1'b0;
    end else begin
      case (state)
        idle: begin
          if (dividend == '0) begin
            state <= finish;
            done  <= 1'b1;
          end else begin
            state <= run;
          end
        end
        run: begin
          if (count == div_count_t'(word_w - 1))
            state <= finish;
        end
        finish: done <= 1'b1;
        default: state <= idle;
      endcase
    end
  end

  // A zero divisor passes every compare, so the quotient fills with ones
  // and the remainder keeps the dividend
  always_ff @(posedge clk) begin
    if (go) begin
      case (state)
        idle: begin
          rem    <= dividend;
          quo    <= '0;
          mask   <= {1'b1, {(word_w-1){1'b0}}};
          div_sh <= shift_t'(divisor) << (word_w - 1);
          count  <= '0;
          if (dividend == '0) begin
            quotient  <= '0;
            remainder <= '0;
          end
        end
        run: begin
          if (fits) begin
            rem <= rem - div_sh[word_w-1:0];
            quo <= quo | mask;
          end
          div_sh <= div_sh >> 1;
          mask   <= mask >> 1;
          count  <= count + 1'b1;
        end
        finish: begin
          quotient  <= quo;
          remainder <= rem;
        end
        default: ;
      endcase
    end
  end

endmodule

`default_nettype wire

/* mult/mult_pipe.sv */
/*
  Three-stage multiplier for integer and Q16.16 words,
  signed or unsigned, with a go/done handshake
*/
`timescale 1ns/1ps
`default_nettype none

module mult_pipe import arith_pkg::*; (
  input  logic  clk,
  input  logic  reset,
  input  logic  go,
  input  logic  is_signed,
  input  logic  fixed,
  input  word_t a,
  input  word_t b,
  output word_t product,
  output logic  done
);

  word_t      a_q;
  word_t      b_q;
  logic       signed_q;
  logic       fixed_q;
  logic       fixed_qq;
  dword_t     a_ext;
  dword_t     b_ext;
  dword_t     full_q;
  logic [2:0] done_chain;

  // Stage 1 registers the operands and the mode bits
  always_ff @(posedge clk) begin
    if (go) begin
      a_q      <= a;
      b_q      <= b;
      signed_q <= is_signed;
      fixed_q  <= fixed;
    end
  end

  // With both operands extended to 64 bits the low 64 product bits
  // are right for signed and unsigned alike
  always_comb begin
    a_ext = {{word_w{signed_q & a_q[word_w-1]}}, a_q};
    b_ext = {{word_w{signed_q & b_q[word_w-1]}}, b_q};
  end

  // Stage 2 holds the full product
  always_ff @(posedge clk) begin
    if (go) begin
      full_q   <= a_ext * b_ext;
      fixed_qq <= fixed_q;
    end
  end

  // Stage 3 picks the low word or the Q16.16 middle word
  always_ff @(posedge clk) begin
    if (go) begin
      if (fixed_qq)
        product <= full_q[frac_w +: word_w];
      else
        product <= full_q[word_w-1:0];
    end
  end

  // One bit per stage, cleared as soon as go drops
  always_ff @(posedge clk) begin
    if (reset || !go)
      done_chain <= '0;
    else
      done_chain <= {done_chain[1:0], 1'b1};
  end

  assign done = done_chain[2];

endmodule

`default_nettype wire

/* common/arith_pkg.sv */
/*
  Shared widths, word types and request/response formats
  for the multiply/divide unit
*/
`default_nettype none

package arith_pkg;

  // Q16.16 split of one word
  localparam int int_w  = 16;
  localparam int frac_w = 16;
  localparam int word_w = int_w + frac_w;

  typedef logic [word_w-1:0]   word_t;
  typedef logic [2*word_w-1:0] dword_t;

  typedef logic [1:0] op_t;

  localparam op_t op_mul   = 2'd0;
  localparam op_t op_fxmul = 2'd1;
  localparam op_t op_div   = 2'd2;

  typedef struct packed {
    op_t   op;
    logic  is_signed;
    word_t a;
    word_t b;
  } arith_req_t;

  typedef struct packed {
    word_t lo;  // product or quotient
    word_t hi;  // remainder, zero for multiplies
  } arith_rsp_t;

  typedef enum logic [1:0] {
    idle,
    run,
    finish
  } div_state_e;

  typedef logic [$clog2(word_w+1)-1:0] div_count_t;

endpackage

`default_nettype wire
